// File: Bender.yml
package:
  name: app_shell

sources:
  - files:
      - rtl/softreg_pkg.sv
      - rtl/softreg_req_if.sv
      - rtl/stage_pipe.sv
      - rtl/scratch_app.sv
      - rtl/resp_or_tree.sv
      - rtl/axil_softreg_bridge.sv
      - rtl/app_shell_top.sv
  - target: simulation
    files:
      - sim/app_shell_assert.sv
      - sim/tb_app_shell.sv

// File: rtl/app_shell_top.sv
`timescale 1ns/1ns

module app_shell_top (
	input  logic                                global_clk,
	input  logic                                global_rst_n,

	input  logic                                awvalid,
	input  logic [softreg_pkg::SR_ADDR_W-1:0]   awaddr,
	output logic                                awready,
	input  logic                                wvalid,
	input  logic [softreg_pkg::SR_DATA_W-1:0]   wdata,
	input  logic [softreg_pkg::SR_DATA_W/8-1:0] wstrb,
	output logic                                wready,
	output logic                                bvalid,
	output logic [1:0]                          bresp,
	input  logic                                bready,

	input  logic                                arvalid,
	input  logic [softreg_pkg::SR_ADDR_W-1:0]   araddr,
	output logic                                arready,
	output logic                                rvalid,
	output logic [softreg_pkg::SR_DATA_W-1:0]   rdata,
	output logic [1:0]                          rresp,
	input  logic                                rready
);
	import softreg_pkg::*;

	softreg_req_if bridge_req ();
	softreg_req_if app_req ();

	logic [SR_REQ_W-1:0] req_packed;
	logic [SR_REQ_W-1:0] req_piped;
	sr_resp_t            app_resp [NUM_APPS];
	sr_resp_t            merged_resp;
	sr_resp_t            bridge_resp;

	// ----------------------------------------
	// Host bridge
	// ----------------------------------------
	// Full-word writes only, wstrb has no effect
	axil_softreg_bridge u_bridge (
		.global_clk   (global_clk),
		.global_rst_n (global_rst_n),
		.awvalid      (awvalid),
		.awaddr       (awaddr),
		.awready      (awready),
		.wvalid       (wvalid),
		.wdata        (wdata),
		.wready       (wready),
		.bvalid       (bvalid),
		.bresp        (bresp),
		.bready       (bready),
		.arvalid      (arvalid),
		.araddr       (araddr),
		.arready      (arready),
		.rvalid       (rvalid),
		.rdata        (rdata),
		.rresp        (rresp),
		.rready       (rready),
		.req          (bridge_req),
		.resp         (bridge_resp)
	);

	// ----------------------------------------
	// Request pipe and broadcast
	// ----------------------------------------
	assign req_packed = {bridge_req.valid, bridge_req.op, bridge_req.addr, bridge_req.data};

	stage_pipe #(.WIDTH(SR_REQ_W), .STAGES(REQ_PIPE_STAGES)) u_req_pipe (
		.global_clk   (global_clk),
		.global_rst_n (global_rst_n),
		.in_bus       (req_packed),
		.out_bus      (req_piped)
	);

	assign app_req.valid = req_piped[SR_REQ_W-1];
	assign app_req.op    = sr_op_t'(req_piped[SR_REQ_W-2]);
	assign app_req.addr  = req_piped[SR_DATA_W +: SR_ADDR_W];
	assign app_req.data  = req_piped[SR_DATA_W-1:0];

	for (genvar i = 0; i < NUM_APPS; i++) begin : g_app
		scratch_app #(.APP_ID(i)) u_app (
			.global_clk   (global_clk),
			.global_rst_n (global_rst_n),
			.req          (app_req),
			.resp         (app_resp[i])
		);
	end

	// ----------------------------------------
	// Response merge and pipe
	// ----------------------------------------
	resp_or_tree u_or_tree (
		.global_clk   (global_clk),
		.global_rst_n (global_rst_n),
		.app_resp     (app_resp),
		.merged       (merged_resp)
	);

	stage_pipe #(.WIDTH($bits(sr_resp_t)), .STAGES(RESP_PIPE_STAGES)) u_resp_pipe (
		.global_clk   (global_clk),
		.global_rst_n (global_rst_n),
		.in_bus       (merged_resp),
		.out_bus      (bridge_resp)
	);

endmodule

// File: rtl/axil_softreg_bridge.sv
`timescale 1ns/1ns

module axil_softreg_bridge (
	input  logic                              global_clk,
	input  logic                              global_rst_n,

	// Write address and data
	input  logic                              awvalid,
	input  logic [softreg_pkg::SR_ADDR_W-1:0] awaddr,
	output logic                              awready,
	input  logic                              wvalid,
	input  logic [softreg_pkg::SR_DATA_W-1:0] wdata,
	output logic                              wready,

	// Write response
	output logic                              bvalid,
	output logic [1:0]                        bresp,
	input  logic                              bready,

	// Read address
	input  logic                              arvalid,
	input  logic [softreg_pkg::SR_ADDR_W-1:0] araddr,
	output logic                              arready,

	// Read data
	output logic                              rvalid,
	output logic [softreg_pkg::SR_DATA_W-1:0] rdata,
	output logic [1:0]                        rresp,
	input  logic                              rready,

	// Soft-register side
	softreg_req_if.issuer                     req,
	input  softreg_pkg::sr_resp_t             resp
);
	import softreg_pkg::*;

	bridge_state_t        state;
	bridge_state_t        state_nxt;
	logic                 wr_pending;
	logic                 wr_accept;
	logic                 rd_accept;
	logic [SR_ADDR_W-1:0] addr_q;
	logic [SR_DATA_W-1:0] data_q;
	logic [SR_DATA_W-1:0] rdata_q;

	// ----------------------------------------
	// Host handshakes
	// ----------------------------------------
	assign wr_pending = awvalid && wvalid;

	assign awready = (state == ST_IDLE);
	assign wready  = (state == ST_IDLE);
	// Hold off the read while a full write is on offer
	assign arready = (state == ST_IDLE) && !wr_pending;

	assign wr_accept = awready && wr_pending;
	assign rd_accept = arready && arvalid;

	assign bvalid = (state == ST_WR_RESP);
	assign bresp  = AXI_RESP_OKAY;
	assign rvalid = (state == ST_RD_RESP);
	assign rresp  = AXI_RESP_OKAY;
	assign rdata  = rdata_q;

	// ----------------------------------------
	// Request toward the applications
	// ----------------------------------------
	assign req.valid = (state == ST_ISSUE_WR) || (state == ST_ISSUE_RD);
	assign req.op    = (state == ST_ISSUE_RD) ? SR_OP_READ : SR_OP_WRITE;
	assign req.addr  = addr_q;
	assign req.data  = data_q;

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				if (wr_accept) begin
					state_nxt = ST_ISSUE_WR;
				end else if (rd_accept) begin
					state_nxt = ST_ISSUE_RD;
				end
			end
			ST_ISSUE_WR: state_nxt = ST_WR_RESP;
			ST_WR_RESP: begin
				if (bready) begin
					state_nxt = ST_IDLE;
				end
			end
			ST_ISSUE_RD: state_nxt = ST_WAIT_RD;
			// Response pipe latency is fixed, just watch for valid
			ST_WAIT_RD: begin
				if (resp.valid) begin
					state_nxt = ST_RD_RESP;
				end
			end
			ST_RD_RESP: begin
				if (rready) begin
					state_nxt = ST_IDLE;
				end
			end
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge global_clk) begin
		if (global_rst_n) begin
			state   <= ST_IDLE;
			rdata_q <= '0;
		end else begin
			state <= state_nxt;
			if (state == ST_WAIT_RD && resp.valid) begin
				rdata_q <= resp.data;
			end
		end
	end

	// Captured access, held until the request is issued
	always_ff @(posedge global_clk) begin
		if (wr_accept) begin
			addr_q <= awaddr;
			data_q <= wdata;
		end else if (rd_accept) begin
			addr_q <= araddr;
		end
	end

endmodule

// File: rtl/resp_or_tree.sv
`timescale 1ns/1ns

module resp_or_tree (
	input  logic                  global_clk,
	input  logic                  global_rst_n,
	input  softreg_pkg::sr_resp_t app_resp [softreg_pkg::NUM_APPS],
	output softreg_pkg::sr_resp_t merged
);
	import softreg_pkg::*;

	sr_resp_t cap_q  [NUM_APPS];
	sr_resp_t pair_q [NUM_APPS/2];

	// ----------------------------------------
	// Capture, pair OR, final OR
	// ----------------------------------------
	always_ff @(posedge global_clk) begin
		if (global_rst_n) begin
			for (int i = 0; i < NUM_APPS; i++) begin
				cap_q[i] <= '0;
			end
			for (int i = 0; i < NUM_APPS/2; i++) begin
				pair_q[i] <= '0;
			end
			merged <= '0;
		end else begin
			for (int i = 0; i < NUM_APPS; i++) begin
				cap_q[i] <= app_resp[i];
			end
			// At most one application answers, so OR is a clean mux
			for (int i = 0; i < NUM_APPS/2; i++) begin
				pair_q[i] <= cap_q[2*i] | cap_q[2*i+1];
			end
			merged <= pair_q[0] | pair_q[1];
		end
	end

endmodule

// File: rtl/scratch_app.sv
`timescale 1ns/1ns

module scratch_app #(
	parameter int APP_ID = 0
) (
	input  logic                  global_clk,
	input  logic                  global_rst_n,
	softreg_req_if.receiver       req,
	output softreg_pkg::sr_resp_t resp
);
	import softreg_pkg::*;

	logic [SR_DATA_W-1:0] regs_q [REGS_PER_APP];
	logic [APP_SEL_W-1:0] app_sel;
	logic [REG_IDX_W-1:0] reg_idx;
	logic                 hit;

	// Every request is broadcast, only the own slot is decoded
	assign app_sel = req.addr[APP_SEL_LSB +: APP_SEL_W];
	assign reg_idx = req.addr[REG_IDX_LSB +: REG_IDX_W];
	assign hit     = req.valid && (app_sel == APP_SEL_W'(APP_ID));

	always_ff @(posedge global_clk) begin
		if (global_rst_n) begin
			for (int i = 0; i < REGS_PER_APP; i++) begin
				regs_q[i] <= '0;
			end
			resp <= '0;
		end else begin
			if (hit && req.op == SR_OP_WRITE) begin
				regs_q[reg_idx] <= req.data;
			end
			// Idle cycles answer with zeros for the OR merge
			if (hit && req.op == SR_OP_READ) begin
				resp.valid <= 1'b1;
				resp.data  <= regs_q[reg_idx];
			end else begin
				resp <= '0;
			end
		end
	end

endmodule

// File: rtl/softreg_pkg.sv
package softreg_pkg;

	// ----------------------------------------
	// Widths
	// ----------------------------------------
	localparam int SR_ADDR_W = 32;
	localparam int SR_DATA_W = 32;

	// Valid, opcode, address and data of one request
	localparam int SR_REQ_W = 1 + 1 + SR_ADDR_W + SR_DATA_W;

	// ----------------------------------------
	// Address map
	// ----------------------------------------
	localparam int NUM_APPS     = 4;
	localparam int REGS_PER_APP = 4;
	localparam int APP_SEL_LSB  = 4;
	localparam int APP_SEL_W    = $clog2(NUM_APPS);
	localparam int REG_IDX_LSB  = 2;
	localparam int REG_IDX_W    = $clog2(REGS_PER_APP);

	// Register pipes around the application side
	localparam int REQ_PIPE_STAGES  = 2;
	localparam int RESP_PIPE_STAGES = 2;

	localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

	typedef enum logic {
		SR_OP_WRITE,
		SR_OP_READ
	} sr_op_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_ISSUE_WR,
		ST_WR_RESP,
		ST_ISSUE_RD,
		ST_WAIT_RD,
		ST_RD_RESP
	} bridge_state_t;

	// All zeros except for a read answer, so responses merge by OR
	typedef struct packed {
		logic                 valid;
		logic [SR_DATA_W-1:0] data;
	} sr_resp_t;

endpackage

// File: rtl/softreg_req_if.sv
`timescale 1ns/1ns

interface softreg_req_if;
	import softreg_pkg::*;

	// No grant signal; a request lives for exactly the cycles valid is high
	logic                 valid;
	sr_op_t               op;
	logic [SR_ADDR_W-1:0] addr;
	logic [SR_DATA_W-1:0] data;

	modport issuer (
		output valid,
		output op,
		output addr,
		output data
	);

	modport receiver (
		input valid,
		input op,
		input addr,
		input data
	);

endinterface

// File: rtl/stage_pipe.sv
`timescale 1ns/1ns

module stage_pipe #(
	parameter int WIDTH  = 1,
	parameter int STAGES = 2
) (
	input  logic             global_clk,
	input  logic             global_rst_n,
	input  logic [WIDTH-1:0] in_bus,
	output logic [WIDTH-1:0] out_bus
);

	logic [WIDTH-1:0] stage_q [STAGES];

	always_ff @(posedge global_clk) begin
		if (global_rst_n) begin
			for (int i = 0; i < STAGES; i++) begin
				stage_q[i] <= '0;
			end
		end else begin
			stage_q[0] <= in_bus;
			// Shift toward the output
			for (int i = 1; i < STAGES; i++) begin
				stage_q[i] <= stage_q[i-1];
			end
		end
	end

	assign out_bus = stage_q[STAGES-1];

endmodule

// File: sim/app_shell_assert.sv
`timescale 1ns/1ns

module app_shell_assert (
	input logic                              global_clk,
	input logic                              global_rst_n,
	input logic                              bvalid,
	input logic                              bready,
	input logic [1:0]                        bresp,
	input logic                              rvalid,
	input logic                              rready,
	input logic [softreg_pkg::SR_DATA_W-1:0] rdata,
	input logic [1:0]                        rresp
);
	import softreg_pkg::*;

	// Number of failed assertions
	int fail_count = 0;

	// ----------------------------------------
	// Reset
	// ----------------------------------------
	a_reset_quiet: assert property (@(posedge global_clk)
		global_rst_n |=> !bvalid && !rvalid)
		else begin
			fail_count++;
			$error("bvalid or rvalid was high during or right after reset");
		end

	// ----------------------------------------
	// Back-pressure
	// ----------------------------------------
	a_b_hold: assert property (@(posedge global_clk) disable iff (global_rst_n)
		bvalid && !bready |=> bvalid)
		else begin
			fail_count++;
			$error("bvalid dropped before bready was seen");
		end

	a_r_hold: assert property (@(posedge global_clk) disable iff (global_rst_n)
		rvalid && !rready |=> rvalid && $stable(rdata))
		else begin
			fail_count++;
			$error("rvalid dropped or rdata changed before rready was seen");
		end

	// Response codes
	a_bresp_okay: assert property (@(posedge global_clk) disable iff (global_rst_n)
		bvalid |-> bresp == AXI_RESP_OKAY)
		else begin
			fail_count++;
			$error("bresp was not OKAY while bvalid was high");
		end

	a_rresp_okay: assert property (@(posedge global_clk) disable iff (global_rst_n)
		rvalid |-> rresp == AXI_RESP_OKAY)
		else begin
			fail_count++;
			$error("rresp was not OKAY while rvalid was high");
		end

endmodule

bind app_shell_top app_shell_assert u_sva (.*);

// File: sim/tb_app_shell.sv
`timescale 1ns/1ns

module tb_app_shell;
	import softreg_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int NUM_TXNS   = 80;
	localparam int HS_LIMIT   = 30;

	logic        global_clk;
	logic        global_rst_n;
	logic        awvalid;
	logic [31:0] awaddr;
	logic        awready;
	logic        wvalid;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wready;
	logic        bvalid;
	logic [1:0]  bresp;
	logic        bready;
	logic        arvalid;
	logic [31:0] araddr;
	logic        arready;
	logic        rvalid;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rready;

	logic [31:0] model [NUM_APPS*REGS_PER_APP];
	int          seed = 32'he63b;
	int          mismatch_count = 0;
	int          hang_count = 0;

	app_shell_top u_dut (.*);

	initial begin
		global_clk = 1'b0;
		forever #(CLK_PERIOD/2) global_clk = ~global_clk;
	end

	// Worst case per transaction, stalls included, is well under 40 cycles
	initial begin
		#((NUM_TXNS * 40 + 8) * CLK_PERIOD);
		$display("Timeout: the transactions did not finish in the allowed time");
		$display("TEST FAILED");
		$finish;
	end

	// ----------------------------------------
	// Host access tasks
	// ----------------------------------------
	task automatic wait_ready(input string what, input bit is_read, input bit is_resp);
		int waited;
		logic seen;
		waited = 0;
		@(negedge global_clk);
		seen = is_resp ? (is_read ? rvalid : bvalid)
			: (is_read ? arready : (awready && wready));
		while (!seen && waited < HS_LIMIT) begin
			@(negedge global_clk);
			seen = is_resp ? (is_read ? rvalid : bvalid)
				: (is_read ? arready : (awready && wready));
			waited++;
		end
		if (!seen) begin
			hang_count++;
			$display("Handshake never completed at %0t: %s", $time, what);
		end
	endtask

	task automatic host_write(input logic [31:0] addr, input logic [31:0] data);
		int stall;
		stall = {$random(seed)} % 8;
		@(posedge global_clk);
		awvalid <= 1'b1;
		awaddr  <= addr;
		wvalid  <= 1'b1;
		wdata   <= data;
		wait_ready("write address and data", 1'b0, 1'b0);
		@(posedge global_clk);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		wait_ready("write response", 1'b0, 1'b1);
		repeat (stall) @(posedge global_clk);
		@(posedge global_clk);
		bready <= 1'b1;
		@(posedge global_clk);
		bready <= 1'b0;
	endtask

	task automatic host_read_check(input logic [31:0] addr, input logic [31:0] expected);
		int stall;
		logic [31:0] got;
		stall = {$random(seed)} % 8;
		@(posedge global_clk);
		arvalid <= 1'b1;
		araddr  <= addr;
		wait_ready("read address", 1'b1, 1'b0);
		@(posedge global_clk);
		arvalid <= 1'b0;
		wait_ready("read data", 1'b1, 1'b1);
		repeat (stall) @(posedge global_clk);
		@(posedge global_clk);
		rready <= 1'b1;
		@(negedge global_clk);
		got = rdata;
		assert (got === expected)
			else begin
				mismatch_count++;
				$display("Mismatch at %0t: rdata at addr %h expected %h, got %h",
					$time, addr, expected, got);
			end
		@(posedge global_clk);
		rready <= 1'b0;
	endtask

	function automatic logic [31:0] slot_addr(input int app, input int idx);
		return (app << APP_SEL_LSB) | (idx << REG_IDX_LSB);
	endfunction

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial begin
		logic [31:0] data;
		awvalid      <= 1'b0;
		awaddr       <= '0;
		wvalid       <= 1'b0;
		wdata        <= '0;
		wstrb        <= 4'hf;
		bready       <= 1'b0;
		arvalid      <= 1'b0;
		araddr       <= '0;
		rready       <= 1'b0;
		global_rst_n <= 1'b1;
		repeat (8) @(posedge global_clk);
		global_rst_n <= 1'b0;

		// Reset values
		for (int a = 0; a < NUM_APPS; a++) begin
			for (int r = 0; r < REGS_PER_APP; r++) begin
				model[a*REGS_PER_APP + r] = '0;
				host_read_check(slot_addr(a, r), 32'h0);
			end
		end

		// Read-back of every address
		for (int a = 0; a < NUM_APPS; a++) begin
			for (int r = 0; r < REGS_PER_APP; r++) begin
				data = $random(seed);
				model[a*REGS_PER_APP + r] = data;
				host_write(slot_addr(a, r), data);
				host_read_check(slot_addr(a, r), model[a*REGS_PER_APP + r]);
			end
		end

		// Top bits keep the values of one index distinct across apps
		for (int r = 0; r < REGS_PER_APP; r++) begin
			for (int a = 0; a < NUM_APPS; a++) begin
				data = $random(seed);
				data[31:30] = a[1:0];
				model[a*REGS_PER_APP + r] = data;
				host_write(slot_addr(a, r), data);
			end
			for (int a = 0; a < NUM_APPS; a++) begin
				host_read_check(slot_addr(a, r), model[a*REGS_PER_APP + r]);
			end
		end

		repeat (4) @(posedge global_clk);
		$display("Summary: %0d mismatches, %0d stalled handshakes, %0d assertion failures",
			mismatch_count, hang_count, u_dut.u_sva.fail_count);
		if (mismatch_count == 0 && hang_count == 0 && u_dut.u_sva.fail_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: verilog.f
rtl/softreg_pkg.sv
rtl/softreg_req_if.sv
rtl/stage_pipe.sv
rtl/scratch_app.sv
rtl/resp_or_tree.sv
rtl/axil_softreg_bridge.sv
rtl/app_shell_top.sv
sim/app_shell_assert.sv
sim/tb_app_shell.sv
